// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_batch_joiner
FILELIST  := project.f
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
+incdir+src
src/jn_pkg.sv
src/operation_control.sv
src/channel_joiner.sv
src/packet_splitter.sv
src/batch_fifo.sv
src/batch_arbiter.sv
src/batch_joiner.sv
sim/batch_joiner_asserts.sv
sim/tb_batch_joiner.sv

// File: sim/batch_joiner_asserts.sv
`timescale 1ns/1ps

`include "jn_macros.svh"

module batch_joiner_asserts (
  input logic                s_clk,
  input logic                s_rst,
  input logic                operation_busy,
  input logic                operation_complete,
  input logic                operation_error,
  input jn_pkg::batch_mask_t batch_start,
  input jn_pkg::chan_mask_t  in_ready [`JN_BATCHES],
  input jn_pkg::out_beat_t   out_beat,
  input logic                out_valid,
  input logic                out_ready,
  input logic                transmission
);

  import jn_pkg::*;

  int         fail_count = 0;
  logic       any_in_ready;
  logic       mid_pkt;
  batch_idx_t pkt_id;

  always_comb begin
    any_in_ready = 1'b0;
    for (int b = 0; b < `JN_BATCHES; b++) begin
      any_in_ready = any_in_ready | (|in_ready[b]);
    end
  end

  // Tag of the packet now on the bus
  always_ff @(posedge s_clk) begin
    if (s_rst) begin
      mid_pkt <= 1'b0;
      pkt_id  <= '0;
    end else if (transmission) begin
      mid_pkt <= !out_beat.last;
      pkt_id  <= out_beat.id;
    end
  end

  reset_quiet: assert property (@(posedge s_clk) s_rst |=> !operation_busy &&
      !operation_complete && !operation_error && !transmission && !out_valid &&
      !any_in_ready && (batch_start == '0))
    else begin
      fail_count++;
      $error("Outputs not idle during or right after reset");
    end

  valid_held: assert property (@(posedge s_clk) disable iff (s_rst)
      out_valid && !out_ready |=> out_valid)
    else begin
      fail_count++;
      $error("out_valid dropped before its beat transferred");
    end

  beat_held: assert property (@(posedge s_clk) disable iff (s_rst)
      out_valid && !out_ready |=> $stable(out_beat))
    else begin
      fail_count++;
      $error("Output beat changed while stalled");
    end

  xfer_flag: assert property (@(posedge s_clk) disable iff (s_rst)
      transmission == (out_valid && out_ready))
    else begin
      fail_count++;
      $error("transmission does not match the output handshake");
    end

  id_stable: assert property (@(posedge s_clk) disable iff (s_rst)
      mid_pkt && out_valid |-> out_beat.id == pkt_id)
    else begin
      fail_count++;
      $error("Output id changed inside a packet");
    end

  complete_pulse: assert property (@(posedge s_clk) disable iff (s_rst)
      operation_complete |-> !operation_busy ##1 !operation_complete)
    else begin
      fail_count++;
      $error("operation_complete is not a single pulse with busy low");
    end

endmodule

bind batch_joiner batch_joiner_asserts i_batch_joiner_asserts (
  .s_clk              (s_clk),
  .s_rst              (s_rst),
  .operation_busy     (operation_busy),
  .operation_complete (operation_complete),
  .operation_error    (operation_error),
  .batch_start        (batch_start),
  .in_ready           (in_ready),
  .out_beat           (out_beat),
  .out_valid          (out_valid),
  .out_ready          (out_ready),
  .transmission       (transmission)
);

// File: sim/tb_batch_joiner.sv
`timescale 1ns/1ps

`include "jn_macros.svh"

module tb_batch_joiner;

  import jn_pkg::*;

  localparam int clk_period = 100;
  // Words sent over all runs
  localparam int total_words = 4 + 5 + 4 + 5 + 5 + 6 + 3 + 5 + 7 + 12 + 10 + 9 + 14;
  localparam int watchdog_cycles = 4 * total_words + 200;

  logic        s_clk = 1'b0;
  logic        s_rst = 1'b1;
  logic        operation_start = 1'b0;
  batch_mask_t use_batch = '0;
  chan_mask_t  use_channels = '0;
  pkt_size_t   pckt_size = '0;
  logic        operation_busy;
  logic        operation_complete;
  logic        operation_error;
  beat_t       in_beat [`JN_BATCHES][`JN_CHANNELS];
  chan_mask_t  in_valid [`JN_BATCHES];
  chan_mask_t  in_ready [`JN_BATCHES];
  out_beat_t   out_beat;
  logic        out_valid;
  logic        out_ready = 1'b1;
  logic        transmission;

  int    seed = 59;
  int    rnd;
  logic  random_ready = 1'b0;
  int    errors = 0;
  int    assert_errors;
  int    complete_count = 0;
  string test_name = "reset";
  int    pkt_len [`JN_BATCHES][`JN_CHANNELS];
  beat_t exp_q [`JN_BATCHES][$];
  beat_t expected_beat;

  batch_joiner i_batch_joiner (
    .s_clk              (s_clk),
    .s_rst              (s_rst),
    .operation_start    (operation_start),
    .use_batch          (use_batch),
    .use_channels       (use_channels),
    .pckt_size          (pckt_size),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .in_beat            (in_beat),
    .in_valid           (in_valid),
    .in_ready           (in_ready),
    .out_beat           (out_beat),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .transmission       (transmission)
  );

  always #(clk_period / 2) s_clk = ~s_clk;

  always @(posedge s_clk) begin
    #10;
    rnd = $random(seed);
    out_ready = random_ready ? rnd[0] : 1'b1;
  end

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      errors++;
      $display("ERROR %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Batch in the top nibble, channel next, word index in the low byte
  function automatic logic [`JN_DATA_WIDTH-1:0] word_of(input int b, input int c, input int i);
    return {b[3:0], c[3:0], i[7:0]};
  endfunction

  function automatic bit queues_empty();
    for (int b = 0; b < `JN_BATCHES; b++) begin
      if (exp_q[b].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Scoreboard on the shared output
  always @(negedge s_clk) begin
    if (operation_complete) begin
      complete_count++;
    end
    if (!s_rst && out_valid && out_ready) begin
      check_value("id against data batch field", out_beat.data[15:12], out_beat.id);
      if (exp_q[out_beat.id].size() == 0) begin
        errors++;
        $display("Test %s: output word %0h for batch %0d arrived with nothing expected",
                 test_name, out_beat.data, out_beat.id);
      end else begin
        expected_beat = exp_q[out_beat.id].pop_front();
        check_value("output data", expected_beat.data, out_beat.data);
        check_value("output last", expected_beat.last, out_beat.last);
      end
    end
  end

  task automatic set_lengths(input int l00, input int l01, input int l10, input int l11);
    pkt_len[0][0] = l00;
    pkt_len[0][1] = l01;
    pkt_len[1][0] = l10;
    pkt_len[1][1] = l11;
  endtask

  // Enabled channels in order, last every size words and on the final word
  task automatic expect_batch(input int b, input chan_mask_t cm, input pkt_size_t size);
    int    total;
    int    count;
    int    n;
    beat_t beat;
    total = 0;
    count = 0;
    n = 0;
    for (int c = 0; c < `JN_CHANNELS; c++) begin
      if (cm[c]) begin
        total += pkt_len[b][c];
      end
    end
    for (int c = 0; c < `JN_CHANNELS; c++) begin
      for (int i = 0; cm[c] && i < pkt_len[b][c]; i++) begin
        n++;
        count++;
        beat.data = word_of(b, c, i);
        beat.last = (count == int'(size)) || (n == total);
        if (beat.last) begin
          count = 0;
        end
        exp_q[b].push_back(beat);
      end
    end
  endtask

  task automatic send_packet(input int b, input int c, input int len);
    for (int i = 0; i < len; i++) begin
      in_beat[b][c].data = word_of(b, c, i);
      in_beat[b][c].last = (i == len - 1);
      in_valid[b][c] = 1'b1;
      do begin
        @(negedge s_clk);
      end while (!in_ready[b][c]);
      @(posedge s_clk);
      #10;
    end
    in_valid[b][c] = 1'b0;
  endtask

  task automatic issue_start(input batch_mask_t bm, input chan_mask_t cm, input pkt_size_t size);
    operation_start = 1'b1;
    use_batch = bm;
    use_channels = cm;
    pckt_size = size;
    @(posedge s_clk);
    #10;
    operation_start = 1'b0;
  endtask

  task automatic bad_start(input string name, input batch_mask_t bm, input chan_mask_t cm,
                           input pkt_size_t size);
    test_name = name;
    issue_start(bm, cm, size);
    @(negedge s_clk);
    check_value("operation_error", 1, operation_error);
    check_value("operation_busy", 0, operation_busy);
    @(negedge s_clk);
    check_value("operation_error one cycle later", 0, operation_error);
    check_value("out_valid", 0, out_valid);
    @(posedge s_clk);
    #10;
  endtask

  task automatic start_while_busy();
    repeat (3) @(posedge s_clk);
    #10;
    issue_start(2'b01, 2'b01, 2);
    @(negedge s_clk);
    check_value("operation_error on start while busy", 0, operation_error);
    check_value("operation_busy on start while busy", 1, operation_busy);
  endtask

  task automatic run_op(input string name, input batch_mask_t bm, input chan_mask_t cm,
                        input pkt_size_t size, input bit poke_busy);
    int done_before;
    test_name = name;
    done_before = complete_count;
    for (int b = 0; b < `JN_BATCHES; b++) begin
      if (bm[b]) begin
        expect_batch(b, cm, size);
      end
    end
    issue_start(bm, cm, size);
    @(negedge s_clk);
    check_value("operation_busy after start", 1, operation_busy);
    check_value("operation_error after start", 0, operation_error);
    @(posedge s_clk);
    #10;
    fork
      if (bm[0] && cm[0]) send_packet(0, 0, pkt_len[0][0]);
      if (bm[0] && cm[1]) send_packet(0, 1, pkt_len[0][1]);
      if (bm[1] && cm[0]) send_packet(1, 0, pkt_len[1][0]);
      if (bm[1] && cm[1]) send_packet(1, 1, pkt_len[1][1]);
      if (poke_busy) start_while_busy();
    join
    // Completion comes only after the final input beat of every batch
    check_value("operation_complete before joining ended", done_before, complete_count);
    while (complete_count == done_before) @(posedge s_clk);
    // Output may still be draining after completion
    while (!queues_empty()) @(posedge s_clk);
    repeat (3) @(posedge s_clk);
    #10;
    check_value("operation_complete pulses", done_before + 1, complete_count);
    check_value("operation_busy after completion", 0, operation_busy);
    check_value("out_valid after drain", 0, out_valid);
  endtask

  initial begin
    for (int b = 0; b < `JN_BATCHES; b++) begin
      in_valid[b] = '0;
      for (int c = 0; c < `JN_CHANNELS; c++) begin
        in_beat[b][c] = '0;
        pkt_len[b][c] = 0;
      end
    end
    repeat (16) @(posedge s_clk);
    #10;
    s_rst = 1'b0;
    set_lengths(4, 5, 0, 0);
    run_op("single_batch_join", 2'b01, 2'b11, 20, 1'b0);
    run_op("cut_by_three", 2'b01, 2'b11, 3, 1'b0);
    set_lengths(0, 5, 0, 0);
    run_op("channel_one_only", 2'b01, 2'b10, 3, 1'b0);
    bad_start("zero_batch_mask", 2'b00, 2'b11, 4);
    bad_start("zero_channel_mask", 2'b11, 2'b00, 4);
    bad_start("zero_packet_size", 2'b11, 2'b11, 0);
    set_lengths(6, 3, 5, 7);
    run_op("both_batches", 2'b11, 2'b11, 4, 1'b1);
    random_ready = 1'b1;
    set_lengths(12, 10, 9, 14);
    run_op("random_backpressure", 2'b11, 2'b11, 5, 1'b0);
    assert_errors = i_batch_joiner.i_batch_joiner_asserts.fail_count;
    $display("Error counts: %0d scoreboard, %0d assertion", errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: src/batch_arbiter.sv
`timescale 1ns/1ps

`include "jn_macros.svh"

module batch_arbiter (
  input  logic                s_clk,
  input  logic                s_rst,
  input  jn_pkg::beat_t       req_beat [`JN_BATCHES],
  input  jn_pkg::batch_mask_t req_valid,
  output jn_pkg::batch_mask_t req_ready,
  output jn_pkg::out_beat_t   out_beat,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                transmission
);

  import jn_pkg::*;

  batch_idx_t pick;
  batch_idx_t grant;
  batch_idx_t sel;
  logic       locked;

  // Lowest index wins
  always_comb begin
    pick = '0;
    for (int i = `JN_BATCHES - 1; i >= 0; i--) begin
      if (req_valid[i]) begin
        pick = batch_idx_t'(i);
      end
    end
  end

  assign sel = locked ? grant : pick;

  always_comb begin
    out_beat.data = req_beat[sel].data;
    out_beat.last = req_beat[sel].last;
    out_beat.id   = sel;
  end

  assign out_valid    = req_valid[sel];
  assign req_ready    = out_ready ? (batch_mask_t'(1) << sel) : '0;
  assign transmission = out_valid && out_ready;

  // Lock as soon as a beat is offered, so a lower batch turning valid
  // cannot pull a beat that is already on the bus
  always_ff @(posedge s_clk) begin
    if (s_rst) begin
      grant  <= '0;
      locked <= 1'b0;
    end else if (transmission && out_beat.last) begin
      locked <= 1'b0;
    end else if (out_valid) begin
      grant  <= sel;
      locked <= 1'b1;
    end
  end

endmodule

// File: src/batch_fifo.sv
`timescale 1ns/1ps

`include "jn_macros.svh"

module batch_fifo #(
  parameter int depth = `JN_FIFO_DEPTH
) (
  input  logic          s_clk,
  input  logic          s_rst,
  input  jn_pkg::beat_t wr_beat,
  input  logic          wr_valid,
  output logic          wr_ready,
  output jn_pkg::beat_t rd_beat,
  output logic          rd_valid,
  input  logic          rd_ready
);

  import jn_pkg::*;

  localparam int aw = $clog2(depth);
  localparam logic [aw:0] full_count = (aw + 1)'(depth);

  beat_t         mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   fill;
  logic          do_wr;
  logic          do_rd;

  assign wr_ready = (fill != full_count);
  assign rd_valid = (fill != '0);
  assign rd_beat  = mem[rd_ptr];

  assign do_wr = wr_valid && wr_ready;
  assign do_rd = rd_valid && rd_ready;

  always_ff @(posedge s_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge s_clk) begin
    if (s_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        fill <= fill + 1'b1;
      end else if (do_rd && !do_wr) begin
        fill <= fill - 1'b1;
      end
    end
  end

endmodule

// File: src/batch_joiner.sv
`timescale 1ns/1ps

`include "jn_macros.svh"

module batch_joiner (
  input  logic                s_clk,
  input  logic                s_rst,
  input  logic                operation_start,
  input  jn_pkg::batch_mask_t use_batch,
  input  jn_pkg::chan_mask_t  use_channels,
  input  jn_pkg::pkt_size_t   pckt_size,
  output logic                operation_busy,
  output logic                operation_complete,
  output logic                operation_error,
  input  jn_pkg::beat_t       in_beat [`JN_BATCHES][`JN_CHANNELS],
  input  jn_pkg::chan_mask_t  in_valid [`JN_BATCHES],
  output jn_pkg::chan_mask_t  in_ready [`JN_BATCHES],
  output jn_pkg::out_beat_t   out_beat,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                transmission
);

  import jn_pkg::*;

  batch_mask_t batch_start;
  batch_mask_t batch_done;

  beat_t       join_beat [`JN_BATCHES];
  batch_mask_t join_valid;
  batch_mask_t join_ready;

  beat_t       cut_beat [`JN_BATCHES];
  batch_mask_t cut_valid;
  batch_mask_t cut_ready;

  beat_t       fifo_beat [`JN_BATCHES];
  batch_mask_t fifo_valid;
  batch_mask_t fifo_ready;

  operation_control i_operation_control (
    .s_clk              (s_clk),
    .s_rst              (s_rst),
    .operation_start    (operation_start),
    .use_batch          (use_batch),
    .use_channels       (use_channels),
    .pckt_size          (pckt_size),
    .batch_done         (batch_done),
    .batch_start        (batch_start),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error)
  );

  // One lane per batch: join, re-cut, buffer
  for (genvar b = 0; b < `JN_BATCHES; b++) begin : g_lane
    channel_joiner i_channel_joiner (
      .s_clk        (s_clk),
      .s_rst        (s_rst),
      .start        (batch_start[b]),
      .use_channels (use_channels),
      .in_beat      (in_beat[b]),
      .in_valid     (in_valid[b]),
      .in_ready     (in_ready[b]),
      .join_beat    (join_beat[b]),
      .join_valid   (join_valid[b]),
      .join_ready   (join_ready[b]),
      .done         (batch_done[b])
    );

    packet_splitter i_packet_splitter (
      .s_clk      (s_clk),
      .s_rst      (s_rst),
      .start      (batch_start[b]),
      .pckt_size  (pckt_size),
      .join_beat  (join_beat[b]),
      .join_valid (join_valid[b]),
      .join_ready (join_ready[b]),
      .cut_beat   (cut_beat[b]),
      .cut_valid  (cut_valid[b]),
      .cut_ready  (cut_ready[b])
    );

    batch_fifo #(
      .depth (`JN_FIFO_DEPTH)
    ) i_batch_fifo (
      .s_clk    (s_clk),
      .s_rst    (s_rst),
      .wr_beat  (cut_beat[b]),
      .wr_valid (cut_valid[b]),
      .wr_ready (cut_ready[b]),
      .rd_beat  (fifo_beat[b]),
      .rd_valid (fifo_valid[b]),
      .rd_ready (fifo_ready[b])
    );
  end

  batch_arbiter i_batch_arbiter (
    .s_clk        (s_clk),
    .s_rst        (s_rst),
    .req_beat     (fifo_beat),
    .req_valid    (fifo_valid),
    .req_ready    (fifo_ready),
    .out_beat     (out_beat),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .transmission (transmission)
  );

endmodule

// File: src/channel_joiner.sv
`timescale 1ns/1ps

`include "jn_macros.svh"

module channel_joiner (
  input  logic               s_clk,
  input  logic               s_rst,
  input  logic               start,
  input  jn_pkg::chan_mask_t use_channels,
  input  jn_pkg::beat_t      in_beat [`JN_CHANNELS],
  input  jn_pkg::chan_mask_t in_valid,
  output jn_pkg::chan_mask_t in_ready,
  output jn_pkg::beat_t      join_beat,
  output logic               join_valid,
  input  logic               join_ready,
  output logic               done
);

  import jn_pkg::*;

  chan_mask_t chan_q;
  chan_mask_t pending;
  chan_mask_t remaining;
  chan_idx_t  sel;
  logic       active;
  logic       sel_final;
  logic       chan_last;

  // Lowest enabled channel not yet served
  always_comb begin
    sel = '0;
    for (int i = `JN_CHANNELS - 1; i >= 0; i--) begin
      if (pending[i]) begin
        sel = chan_idx_t'(i);
      end
    end
  end

  assign remaining = pending & ~(chan_mask_t'(1) << sel);
  assign sel_final = (remaining == '0);

  always_comb begin
    join_beat.data = in_beat[sel].data;
    // Only the final channel closes the joined stream
    join_beat.last = in_beat[sel].last && sel_final;
  end

  assign join_valid = active && in_valid[sel];
  assign in_ready   = active ? (chan_mask_t'(join_ready) << sel) : '0;
  assign chan_last  = join_valid && join_ready && in_beat[sel].last;
  assign done       = chan_last && sel_final;

  always_ff @(posedge s_clk) begin
    if (s_rst) begin
      chan_q  <= '0;
      pending <= '0;
      active  <= 1'b0;
    end else if (!active) begin
      // While idle the mask follows the input, so at start it holds
      // the value seen on the edge that issued the command
      if (start) begin
        pending <= chan_q;
        active  <= 1'b1;
      end else begin
        chan_q <= use_channels;
      end
    end else if (chan_last) begin
      pending <= remaining;
      if (sel_final) begin
        active <= 1'b0;
      end
    end
  end

endmodule

// File: src/jn_macros.svh
`ifndef JN_MACROS_SVH
`define JN_MACROS_SVH

// Stream data width in bits
`define JN_DATA_WIDTH 16

// Input streams per batch
`define JN_CHANNELS 2

// Number of batch lanes
`define JN_BATCHES 2

// Width of the requested packet length
`define JN_SIZE_WIDTH 8

// Words buffered per batch
`define JN_FIFO_DEPTH 16

`endif

// File: src/jn_pkg.sv
`include "jn_macros.svh"

package jn_pkg;

  // Batch number, carried as the output id
  typedef logic [$clog2(`JN_BATCHES)-1:0] batch_idx_t;

  // Channel number inside one batch
  typedef logic [$clog2(`JN_CHANNELS)-1:0] chan_idx_t;

  // One enable bit per channel
  typedef logic [`JN_CHANNELS-1:0] chan_mask_t;

  // One bit per batch
  typedef logic [`JN_BATCHES-1:0] batch_mask_t;

  // Packet length in words
  typedef logic [`JN_SIZE_WIDTH-1:0] pkt_size_t;

  // Beat inside a batch lane and on the input channels
  typedef struct packed {
    logic [`JN_DATA_WIDTH-1:0] data;
    logic                      last;
  } beat_t;

  // Beat on the shared output, tagged with its batch
  typedef struct packed {
    logic [`JN_DATA_WIDTH-1:0] data;
    logic                      last;
    batch_idx_t                id;
  } out_beat_t;

endpackage

// File: src/operation_control.sv
`timescale 1ns/1ps

module operation_control (
  input  logic                s_clk,
  input  logic                s_rst,
  input  logic                operation_start,
  input  jn_pkg::batch_mask_t use_batch,
  input  jn_pkg::chan_mask_t  use_channels,
  input  jn_pkg::pkt_size_t   pckt_size,
  input  jn_pkg::batch_mask_t batch_done,
  output jn_pkg::batch_mask_t batch_start,
  output logic                operation_busy,
  output logic                operation_complete,
  output logic                operation_error
);

  import jn_pkg::*;

  batch_mask_t pending;
  batch_mask_t pending_next;
  logic        config_ok;

  // Every field of the command must select something
  assign config_ok = (|use_batch) && (|use_channels) && (|pckt_size);

  // Batches still joining after this cycle's done pulses
  assign pending_next = pending & ~batch_done;

  always_ff @(posedge s_clk) begin
    if (s_rst) begin
      pending            <= '0;
      batch_start        <= '0;
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
    end else begin
      batch_start        <= '0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      if (!operation_busy) begin
        if (operation_start) begin
          if (config_ok) begin
            pending        <= use_batch;
            batch_start    <= use_batch;
            operation_busy <= 1'b1;
          end else begin
            operation_error <= 1'b1;
          end
        end
      end else begin
        pending <= pending_next;
        // Last selected batch has finished joining
        if (pending_next == '0) begin
          operation_busy     <= 1'b0;
          operation_complete <= 1'b1;
        end
      end
    end
  end

endmodule

// File: src/packet_splitter.sv
`timescale 1ns/1ps

module packet_splitter (
  input  logic              s_clk,
  input  logic              s_rst,
  input  logic              start,
  input  jn_pkg::pkt_size_t pckt_size,
  input  jn_pkg::beat_t     join_beat,
  input  logic              join_valid,
  output logic              join_ready,
  output jn_pkg::beat_t     cut_beat,
  output logic              cut_valid,
  input  logic              cut_ready
);

  import jn_pkg::*;

  pkt_size_t size_q;
  pkt_size_t count;
  pkt_size_t count_next;
  logic      active;
  logic      size_hit;
  logic      xfer;

  assign count_next = count + 1'b1;
  assign size_hit   = (count_next == size_q);
  assign xfer       = join_valid && cut_ready;

  assign cut_valid  = join_valid;
  assign join_ready = cut_ready;

  always_comb begin
    cut_beat      = join_beat;
    cut_beat.last = join_beat.last || size_hit;
  end

  always_ff @(posedge s_clk) begin
    if (s_rst) begin
      size_q <= '0;
      count  <= '0;
      active <= 1'b0;
    end else if (!active) begin
      count <= '0;
      // Size tracks the input until the lane starts
      if (start) begin
        active <= 1'b1;
      end else begin
        size_q <= pckt_size;
      end
    end else if (xfer) begin
      count <= cut_beat.last ? '0 : count_next;
      if (join_beat.last) begin
        active <= 1'b0;
      end
    end
  end

endmodule
